// ==== verilog/branchPredPkg.sv ====
package branchPredPkg;

    // Table geometry
    localparam int ghrWidth       = 12;                  // Global history length
    localparam int lhtIndexWidth  = 10;                  // Address bits picking a local history
    localparam int localHistWidth = 10;                  // Local history length

    localparam int globalEntries = 1 << ghrWidth;        // Global PHT and chooser size
    localparam int lhtEntries    = 1 << lhtIndexWidth;   // Local history table size
    localparam int localEntries  = 1 << localHistWidth;  // Local PHT size

    // MSB is the prediction bit
    typedef logic [1:0] counterT;

    localparam counterT counterInit = 2'b01;             // Weakly not taken / weakly local

    // MIPS opcodes of conditional branches
    localparam logic [5:0] opRegimm = 6'b000001;
    localparam logic [5:0] opBeq    = 6'b000100;
    localparam logic [5:0] opBne    = 6'b000101;
    localparam logic [5:0] opBlez   = 6'b000110;
    localparam logic [5:0] opBgtz   = 6'b000111;

    // REGIMM rt field codes
    localparam logic [4:0] rtBltz   = 5'b00000;
    localparam logic [4:0] rtBgez   = 5'b00001;
    localparam logic [4:0] rtBltzal = 5'b10000;
    localparam logic [4:0] rtBgezal = 5'b10001;

    // Saturating step of a two-bit counter toward the outcome
    function automatic counterT counterNext(counterT count, logic up);
        counterT result;
        if (up) begin
            result = (count == 2'b11) ? count : count + 2'd1;  // Hold at strongly taken
        end else begin
            result = (count == 2'b00) ? count : count - 2'd1;  // Hold at strongly not taken
        end
        return result;
    endfunction

endpackage

// ==== verilog/branchDecoder.sv ====
module branchDecoder
    import branchPredPkg::*;
(
    input  logic [31:0] instr,
    output logic        isBranch
);

    logic [5:0] opcode;
    logic [4:0] rt;
    logic       regimmBranch;

    assign opcode = instr[31:26];
    assign rt     = instr[20:16];

    // Only four rt codes under REGIMM are branches
    always_comb begin
        case (rt)
            rtBltz,
            rtBgez,
            rtBltzal,
            rtBgezal: regimmBranch = 1'b1;
            default:  regimmBranch = 1'b0;  // Traps and the like
        endcase
    end

    always_comb begin
        case (opcode)
            opRegimm: isBranch = regimmBranch;
            opBeq,
            opBne,
            opBlez,
            opBgtz:   isBranch = 1'b1;
            default:  isBranch = 1'b0;      // Jumps and everything else
        endcase
    end

endmodule

// ==== verilog/globalPredictor.sv ====
module globalPredictor
    import branchPredPkg::*;
(
    input  logic                CLK,
    input  logic                RESET,
    input  logic                resolveValid,
    input  logic                resolveTaken,
    output logic                globalPred,
    output logic [ghrWidth-1:0] globalHistory
);

    logic [ghrWidth-1:0] ghr;                   // Global history register
    counterT             pht [globalEntries];   // Global pattern table
    counterT             currentCount;

    // The index does not depend on the address, so one read serves
    // both the fetch-side prediction and the resolve-side training
    assign currentCount  = pht[ghr];
    assign globalPred    = currentCount[1];     // MSB is the prediction
    assign globalHistory = ghr;

    // Newest outcome enters at the LSB
    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            ghr <= '0;
        end else if (resolveValid) begin
            ghr <= {ghr[ghrWidth-2:0], resolveTaken};
        end
    end

    // Train the counter at the pre-edge history
    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            for (int i = 0; i < globalEntries; i++) begin
                pht[i] <= counterInit;
            end
        end else if (resolveValid) begin
            pht[ghr] <= counterNext(currentCount, resolveTaken);
        end
    end

endmodule

// ==== verilog/localPredictor.sv ====
module localPredictor
    import branchPredPkg::*;
(
    input  logic        CLK,
    input  logic        RESET,
    input  logic        resolveValid,
    input  logic        resolveTaken,
    input  logic [31:0] instrAddr,
    input  logic [31:0] resolveAddr,
    output logic        localPred,
    output logic        localResolvePred
);

    logic [localHistWidth-1:0] lht [lhtEntries];    // Per-address histories
    counterT                   lpt [localEntries];  // Local pattern table

    logic [lhtIndexWidth-1:0]  fetchIndex;
    logic [lhtIndexWidth-1:0]  resolveIndex;
    logic [localHistWidth-1:0] fetchHist;
    logic [localHistWidth-1:0] resolveHist;
    counterT                   fetchCount;
    counterT                   resolveCount;

    // Word aligned, so the two low address bits are dropped
    assign fetchIndex   = instrAddr[lhtIndexWidth+1:2];
    assign resolveIndex = resolveAddr[lhtIndexWidth+1:2];

    // Fetch side
    assign fetchHist  = lht[fetchIndex];
    assign fetchCount = lpt[fetchHist];
    assign localPred  = fetchCount[1];

    // Resolve side, also used by the chooser to see which component was right
    assign resolveHist      = lht[resolveIndex];
    assign resolveCount     = lpt[resolveHist];
    assign localResolvePred = resolveCount[1];

    // Shift the outcome into the resolved branch's own history
    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            for (int i = 0; i < lhtEntries; i++) begin
                lht[i] <= '0;
            end
        end else if (resolveValid) begin
            lht[resolveIndex] <= {resolveHist[localHistWidth-2:0], resolveTaken};
        end
    end

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            for (int i = 0; i < localEntries; i++) begin
                lpt[i] <= counterInit;
            end
        end else if (resolveValid) begin
            lpt[resolveHist] <= counterNext(resolveCount, resolveTaken);  // Old history
        end
    end

endmodule

// ==== verilog/choicePredictor.sv ====
module choicePredictor
    import branchPredPkg::*;
(
    input  logic                CLK,
    input  logic                RESET,
    input  logic                isBranch,
    input  logic                globalPred,
    input  logic                localPred,
    input  logic                localResolvePred,
    input  logic                resolveValid,
    input  logic                resolveTaken,
    input  logic [ghrWidth-1:0] globalHistory,
    output logic                taken
);

    counterT chooser [globalEntries];   // MSB set means trust global
    counterT choiceCount;
    logic    useGlobal;
    logic    nextTaken;
    logic    disagree;
    logic    globalRight;

    assign choiceCount = chooser[globalHistory];
    assign useGlobal   = choiceCount[1];

    // Non-branch words never predict taken
    assign nextTaken = isBranch & (useGlobal ? globalPred : localPred);

    // Training only happens when the components disagree
    assign disagree    = globalPred != localResolvePred;
    assign globalRight = globalPred == resolveTaken;

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            taken <= 1'b0;
        end else begin
            taken <= nextTaken;     // One cycle after instr
        end
    end

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            for (int i = 0; i < globalEntries; i++) begin
                chooser[i] <= counterInit;  // Weakly prefer local
            end
        end else if (resolveValid && disagree) begin
            chooser[globalHistory] <= counterNext(choiceCount, globalRight);
        end
    end

endmodule

// ==== verilog/hybridPredictor.sv ====
module hybridPredictor
    import branchPredPkg::*;
(
    input  logic        CLK,
    input  logic        RESET,
    input  logic [31:0] instr,
    input  logic [31:0] instrAddr,
    input  logic        resolveValid,
    input  logic        resolveTaken,
    input  logic [31:0] resolveAddr,
    output logic        taken
);

    logic                isBranch;
    logic                globalPred;
    logic [ghrWidth-1:0] globalHistory;
    logic                localPred;
    logic                localResolvePred;

    branchDecoder decoderInst (
        .instr    (instr),
        .isBranch (isBranch)
    );

    globalPredictor globalInst (
        .CLK           (CLK),
        .RESET         (RESET),
        .resolveValid  (resolveValid),
        .resolveTaken  (resolveTaken),
        .globalPred    (globalPred),
        .globalHistory (globalHistory)
    );

    // Fetch and resolve addresses index the local tables independently
    localPredictor localInst (
        .CLK              (CLK),
        .RESET            (RESET),
        .resolveValid     (resolveValid),
        .resolveTaken     (resolveTaken),
        .instrAddr        (instrAddr),
        .resolveAddr      (resolveAddr),
        .localPred        (localPred),
        .localResolvePred (localResolvePred)
    );

    choicePredictor choiceInst (
        .CLK              (CLK),
        .RESET            (RESET),
        .isBranch         (isBranch),
        .globalPred       (globalPred),
        .localPred        (localPred),
        .localResolvePred (localResolvePred),
        .resolveValid     (resolveValid),
        .resolveTaken     (resolveTaken),
        .globalHistory    (globalHistory),
        .taken            (taken)
    );

endmodule

// ==== include/predictorModel.svh ====
`ifndef PREDICTOR_MODEL_SVH
`define PREDICTOR_MODEL_SVH

// Shadow copies of every predictor table
logic [ghrWidth-1:0]       modelGhr;
counterT                   modelGpt [globalEntries];
logic [localHistWidth-1:0] modelLht [lhtEntries];
counterT                   modelLpt [localEntries];
counterT                   modelChooser [globalEntries];
logic                      modelTaken;

function automatic logic modelIsBranch(logic [31:0] word);
    logic [4:0] rt;
    rt = word[20:16];
    case (word[31:26])
        opRegimm: return rt inside {rtBltz, rtBgez, rtBltzal, rtBgezal};
        opBeq, opBne, opBlez, opBgtz: return 1'b1;
        default: return 1'b0;
    endcase
endfunction

// Two-bit counter moves one step, held at 00 and 11
function automatic counterT saturateStep(counterT count, logic up);
    counterT result;
    result = count;
    if (up && count != 2'b11) begin
        result = count + 2'd1;
    end else if (!up && count != 2'b00) begin
        result = count - 2'd1;
    end
    return result;
endfunction

task automatic modelReset();
    modelGhr   = '0;
    modelTaken = 1'b0;
    for (int i = 0; i < globalEntries; i++) begin
        modelGpt[i]     = counterInit;
        modelChooser[i] = counterInit;
    end
    for (int i = 0; i < lhtEntries; i++) begin
        modelLht[i] = '0;
    end
    for (int i = 0; i < localEntries; i++) begin
        modelLpt[i] = counterInit;
    end
endtask

// One clock edge: predict from the old state, then train
task automatic modelStep(logic [31:0] word, logic [31:0] addr, logic valid,
                         logic outcome, logic [31:0] resAddr);
    logic [lhtIndexWidth-1:0]  resIndex;
    logic [localHistWidth-1:0] resHist;
    logic                      gPred;
    logic                      lPred;
    logic                      lResPred;
    gPred    = modelGpt[modelGhr][1];
    lPred    = modelLpt[modelLht[addr[lhtIndexWidth+1:2]]][1];
    resIndex = resAddr[lhtIndexWidth+1:2];
    resHist  = modelLht[resIndex];
    lResPred = modelLpt[resHist][1];
    modelTaken = modelIsBranch(word) &&
                 (modelChooser[modelGhr][1] ? gPred : lPred);
    if (valid) begin
        if (gPred != lResPred) begin
            modelChooser[modelGhr] = saturateStep(modelChooser[modelGhr], gPred == outcome);
        end
        modelGpt[modelGhr] = saturateStep(modelGpt[modelGhr], outcome);
        modelLpt[resHist]  = saturateStep(modelLpt[resHist], outcome);
        modelLht[resIndex] = {resHist[localHistWidth-2:0], outcome};
        modelGhr           = {modelGhr[ghrWidth-2:0], outcome};
    end
endtask

`endif

// ==== verification/hybridPredictorTb.sv ====
module hybridPredictorTb
    import branchPredPkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    logic        CLK;
    logic        RESET;
    logic [31:0] instr;
    logic [31:0] instrAddr;
    logic        resolveValid;
    logic        resolveTaken;
    logic [31:0] resolveAddr;
    logic        taken;

    int          seed;
    logic [31:0] addrPool [8];      // Small pool so histories train

    `include "predictorModel.svh"

    hybridPredictor dut_i (
        .CLK          (CLK),
        .RESET        (RESET),
        .instr        (instr),
        .instrAddr    (instrAddr),
        .resolveValid (resolveValid),
        .resolveTaken (resolveTaken),
        .resolveAddr  (resolveAddr),
        .taken        (taken)
    );

    always #10 CLK = ~CLK;          // 20 ns period

    function automatic logic [31:0] nextRandom();
        return $random(seed);
    endfunction

    // One of the eight conditional branch encodings, other fields random
    function automatic logic [31:0] branchWord(logic [2:0] sel, logic [31:0] bits);
        logic [5:0] op;
        logic [4:0] rt;
        op = opRegimm;
        rt = bits[20:16];
        case (sel)
            3'd0: rt = rtBltz;
            3'd1: rt = rtBgez;
            3'd2: rt = rtBltzal;
            3'd3: rt = rtBgezal;
            3'd4: op = opBeq;
            3'd5: op = opBne;
            3'd6: op = opBlez;
            default: op = opBgtz;
        endcase
        return {op, bits[25:21], rt, bits[15:0]};
    endfunction

    // Words that look close to a branch but are not one
    function automatic logic [31:0] nearMissWord(logic [2:0] sel, logic [31:0] bits);
        logic [31:0] word;
        case (sel)
            3'd0: word = {opRegimm, bits[25:21], 5'b00010, bits[15:0]};  // BLTZL
            3'd1: word = {opRegimm, bits[25:21], 5'b01000, bits[15:0]};  // TGEI
            3'd2: word = {opRegimm, bits[25:21], 5'b10011, bits[15:0]};
            3'd3: word = {opRegimm, bits[25:21], 5'b11111, bits[15:0]};
            3'd4,
            3'd6: word = {6'b000010, bits[25:0]};                       // J
            default: word = {6'b000011, bits[25:0]};                    // JAL
        endcase
        return word;
    endfunction

    function automatic logic [31:0] pickInstr();
        logic [31:0] r;
        logic [31:0] bits;
        logic [31:0] word;
        r    = nextRandom();
        bits = nextRandom();
        case (r[1:0])
            2'd0,
            2'd1: word = branchWord(r[4:2], bits);
            2'd2: word = nearMissWord(r[4:2], bits);
            default: word = bits;     // Anything at all
        endcase
        return word;
    endfunction

    function automatic logic [31:0] pickAddr();
        logic [31:0] r;
        r = nextRandom();
        return addrPool[r[2:0]];
    endfunction

    task automatic checkPrediction(input logic expected, input logic actual, input string what);
        if (actual !== expected) begin
            $display("[FAIL] %0t ns: %s, expected taken=%0b, got %0b", $time, what,
                     expected, actual);
            $display("TEST FAILED");
            $fatal(1, "Prediction mismatch");
        end
    endtask

    // Drive one cycle, then check the edge that sampled the previous cycle's inputs
    task automatic applyCycle(logic [31:0] word, logic [31:0] addr, logic valid,
                              logic outcome, logic [31:0] resAddr);
        @(posedge CLK);
        instr        <= word;
        instrAddr    <= addr;
        resolveValid <= valid;
        resolveTaken <= outcome;
        resolveAddr  <= resAddr;
        @(negedge CLK);
        checkPrediction(modelTaken, taken, "taken against model");
        modelStep(word, addr, valid, outcome, resAddr);
    endtask

    task automatic idleCycle();
        applyCycle(32'h0, 32'h0, 1'b0, 1'b0, 32'h0);  // SLL, never a branch
    endtask

    // One cycle of the random stream, resolving about half the time
    task automatic randomCycle();
        logic [31:0] word;
        logic [31:0] addr;
        logic [31:0] coin;
        logic [31:0] resAddr;
        word    = pickInstr();
        addr    = pickAddr();
        coin    = nextRandom();
        resAddr = pickAddr();
        applyCycle(word, addr, coin[0], coin[1], resAddr);
    endtask

    task automatic waitResetRelease();
        logic released;
        released = 1'b0;
        for (int i = 0; i < 20 && !released; i++) begin
            @(negedge CLK);
            released = RESET;
        end
        if (!released) begin
            $display("Timed out waiting for reset to be released");
            $display("TEST FAILED");
            $fatal(1, "Reset timeout");
        end
    endtask

    task automatic doReset();
        @(posedge CLK);
        RESET        <= 1'b0;
        instr        <= 32'h0;
        instrAddr    <= 32'h0;
        resolveValid <= 1'b0;
        resolveTaken <= 1'b0;
        resolveAddr  <= 32'h0;
        repeat (5) @(posedge CLK);
        RESET <= 1'b1;
        modelReset();
        waitResetRelease();
        checkPrediction(1'b0, taken, "taken right after reset");
    endtask

    // Every branch encoding at every pool address, no resolves
    task automatic checkColdBranches();
        for (int sel = 0; sel < 8; sel++) begin
            for (int a = 0; a < 8; a++) begin
                applyCycle(branchWord(3'(sel), nextRandom()), addrPool[a], 1'b0, 1'b0, 32'h0);
                checkPrediction(1'b0, taken, "untrained branch");
            end
        end
        idleCycle();
        checkPrediction(1'b0, taken, "last untrained branch");
    endtask

    initial begin
        seed         = 32'h016feb56;
        CLK          = 1'b0;
        RESET        <= 1'b0;
        instr        <= 32'h0;
        instrAddr    <= 32'h0;
        resolveValid <= 1'b0;
        resolveTaken <= 1'b0;
        resolveAddr  <= 32'h0;
        for (int i = 0; i < 8; i++) begin
            addrPool[i] = 32'h0040_0100 + 32'(i) * 32'h0000_0024;
        end

        doReset();
        checkColdBranches();

        // Saturate one address with taken outcomes
        for (int i = 0; i < 24; i++) begin
            applyCycle(32'h0, 32'h0, 1'b1, 1'b1, addrPool[3]);
        end
        applyCycle(branchWord(3'd4, nextRandom()), addrPool[3], 1'b0, 1'b0, 32'h0);
        idleCycle();
        checkPrediction(1'b1, taken, "saturated branch");

        // Non-branch words with trained tables
        for (int i = 0; i < 64; i++) begin
            applyCycle(nearMissWord(3'(i), nextRandom()), addrPool[3], 1'b0, 1'b0, 32'h0);
            checkPrediction(1'b0, taken, "non-branch word");
        end
        idleCycle();

        // Alternating outcomes at one address
        for (int i = 0; i < 64; i++) begin
            applyCycle(branchWord(3'(i), nextRandom()), addrPool[5], 1'b1, i[0], addrPool[5]);
        end
        idleCycle();

        // Long mixed stream
        for (int i = 0; i < 2000; i++) begin
            randomCycle();
        end
        idleCycle();

        doReset();
        checkColdBranches();

        $display("TEST PASSED");
        $finish;
    end

    initial begin
        #300000;                  // Far beyond the expected run length
        $display("Simulation watchdog expired before the test finished");
        $display("TEST FAILED");
        $fatal(1, "Watchdog timeout");
    end

endmodule

// ==== filelist.f ====
+incdir+include
verilog/branchPredPkg.sv
verilog/branchDecoder.sv
verilog/globalPredictor.sv
verilog/localPredictor.sv
verilog/choicePredictor.sv
verilog/hybridPredictor.sv
verification/hybridPredictorTb.sv

// ==== run.sh ====
#!/bin/bash
# Build and run the branch predictor testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing -f filelist.f --top-module hybridPredictorTb -o simv \
    > build.log 2>&1 \
    || { echo "Compilation failed, see build.log"; cat build.log; exit 1; }

./obj_dir/simv > sim.log 2>&1
cat sim.log

grep -q "TEST FAILED" sim.log && { echo "Simulation reported a failure"; exit 1; }
grep -q "TEST PASSED" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation finished cleanly"
exit 0
